// ==== verilog.f ====
oserdes_pkg.sv
oserdes_pll.sv
tx_word_buffer.sv
oserdes_serializer.sv
serial_tx_top.sv
tb_serial_tx.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_serial_tx -f verilog.f -o tb_serial_tx \
	&& ./obj_dir/tb_serial_tx > sim.log 2>&1 \
	|| echo "build or simulation stopped early" >> sim.log
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

// ==== tb_serial_tx.sv ====
`timescale 1ns/1ps

module tb_serial_tx;

	localparam int WIDTH = oserdes_pkg::WIDTH; // bits per word and cycles per strobe
	localparam int LOCK_CYCLES = oserdes_pkg::LOCK_CYCLES; // modeled pll acquisition
	localparam int NUM_WORDS = 12; // table length
	localparam int ACK_TIMEOUT = 200; // long enough to cover the lock delay
	localparam int RELEASE_TIMEOUT = 8; // ack must drop well inside this
	localparam int DRAIN_TIMEOUT = 300; // cycles for the last words to reach the line
	localparam int IDLE_WORDS_AFTER = 4; // idle words watched once the table is done
	localparam logic [15:0] LFSR_SEED = 16'd40188;

	logic clock;
	logic rst_n;
	logic req;
	logic [WIDTH-1:0] data;
	logic ack;
	logic serial_out;
	logic serializer_strobe;
	logic locked;

	// host words, none of them equal to the idle word
	logic [WIDTH-1:0] data_table [NUM_WORDS] = '{
		8'ha5, 8'h5a, 8'h81, 8'h7e, 8'hc3, 8'h01,
		8'hff, 8'h00, 8'h96, 8'h69, 8'h18, 8'he7
	};

	// cycles before each req, zero means back to back with the previous handshake
	// entry 0 goes up right at reset release, long before lock
	int gap_table [NUM_WORDS] = '{
		0, 0, 0, 20, 3, 0, 0, 0, 12, 1, 0, 30
	};

	// scoreboard
	logic [WIDTH-1:0] expected_words [$]; // acked but not yet seen on the line
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	bit timed_out = 1'b0; // stops the table loop after a hung wait
	int idle_words = 0; // idle words rebuilt from the line
	int data_words = 0; // non-idle words rebuilt from the line

	logic [15:0] lfsr_state; // random gap source

	// line monitor state
	int edges_since_reset = 0; // rising edges with rst_n high
	int cycle = 0; // falling edge count
	int last_strobe_cycle = 0;
	bit strobe_seen = 1'b0;
	bit lock_seen = 1'b0;
	logic prev_ack = 1'b0;
	logic prev_req = 1'b0;

	// serial capture state
	logic [WIDTH-1:0] rebuilt; // word being shifted in
	int bit_count = 0;
	bit collecting = 1'b0;

	serial_tx_top serial_tx_top_inst (
		.clock             (clock),
		.rst_n             (rst_n),
		.req               (req),
		.data              (data),
		.ack               (ack),
		.serial_out        (serial_out),
		.serializer_strobe (serializer_strobe),
		.locked            (locked)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	// single compare point, every check goes through here
	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t: %s, got %0h expected %0h", $time, what, actual,
				expected);
		end
	endtask

	// 16 bit fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	// one lfsr step per bit taken
	task automatic random_bits(input int count, output int value);
		value = 0;
		for (int b = 0; b < count; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]); // new bit enters at the lsb
		end
	endtask

	// compare a rebuilt word against what the host handed in
	task automatic score_word(input logic [WIDTH-1:0] value);
		logic [WIDTH-1:0] wanted;
		if (value == oserdes_pkg::IDLE_WORD) begin
			idle_words++; // filler between host words
		end else if (expected_words.size() == 0) begin
			data_words++;
			check_value(32'(value), 32'(oserdes_pkg::IDLE_WORD),
				"line word with no request pending"); // duplicate or garbage
		end else begin
			data_words++;
			wanted = expected_words.pop_front();
			check_value(32'(value), 32'(wanted), "serial word order");
		end
	endtask

	// four phase handshake for one word, host side
	task automatic send_word(input logic [WIDTH-1:0] value, input bit slot_free);
		int wait_cycles;
		bit linked; // link was up when req went high
		linked = locked;
		data = value;
		req = 1'b1;
		wait_cycles = 0;
		while (!ack && wait_cycles < ACK_TIMEOUT) begin
			@(posedge clock);
			#2;
			wait_cycles++;
		end
		if (!ack) begin
			$display("timeout: word %0h got no ack within %0d cycles", value, ACK_TIMEOUT);
			timeouts++;
			timed_out = 1'b1;
			req = 1'b0;
		end else begin
			expected_words.push_back(value); // the buffer owns the word from here
			check_value(32'(locked), 1, "ack on a locked link");
			if (slot_free) begin
				check_value(wait_cycles, 1, "ack one cycle after req on a free slot");
			end else if (linked) begin
				check_value(32'(wait_cycles <= WIDTH + 1), 1,
					"ack wait within one strobe period"); // back-pressure bound
			end
			req = 1'b0;
			wait_cycles = 0;
			while (ack && wait_cycles < RELEASE_TIMEOUT) begin
				@(posedge clock);
				#2;
				wait_cycles++;
			end
			if (ack) begin
				$display("timeout: ack for word %0h stayed high after req dropped", value);
				timeouts++;
				timed_out = 1'b1;
			end else begin
				check_value(wait_cycles, 1, "ack drop one cycle after req");
			end
		end
	endtask

	// rst_n changes 2 ns after the edge, so it is stable here
	always @(posedge clock) begin
		if (rst_n) begin
			edges_since_reset++;
		end
	end

	// reset state, lock time, strobe period and ack protocol, sampled mid cycle
	always @(negedge clock) begin
		cycle++;
		if (!locked) begin
			if (lock_seen && rst_n) begin
				check_value(32'(locked), 1, "locked stays high once reached");
			end else begin
				check_value(32'(ack), 0, "ack before lock");
				check_value(32'(serializer_strobe), 0, "strobe before lock");
				check_value(32'(serial_out), 0, "serial line before lock");
			end
		end else if (!lock_seen) begin
			lock_seen = 1'b1;
			check_value(32'(edges_since_reset >= LOCK_CYCLES &&
				edges_since_reset <= LOCK_CYCLES + WIDTH + 2), 1,
				"lock time after reset release");
		end
		if (serializer_strobe) begin
			if (strobe_seen) begin
				check_value(cycle - last_strobe_cycle, WIDTH, "strobe period");
			end
			strobe_seen = 1'b1;
			last_strobe_cycle = cycle;
		end
		if (ack && !prev_ack) begin
			check_value(32'(prev_req), 1, "ack rose without req"); // req seen the cycle before
		end
		prev_ack = ack;
		prev_req = req;
	end

	// rebuild one word from the WIDTH cycles after each strobe
	always @(negedge clock) begin
		if (collecting) begin
			rebuilt = {rebuilt[WIDTH-2:0], serial_out}; // msb arrives first
			bit_count++;
			if (bit_count == WIDTH) begin
				collecting = 1'b0;
				score_word(rebuilt);
			end
		end
		// next strobe shares a cycle with the previous word's lsb
		if (serializer_strobe && locked) begin
			collecting = 1'b1;
			bit_count = 0;
		end
	end

	initial begin
		int gap;
		int extra;
		int wait_cycles;
		int idle_start;
		lfsr_state = LFSR_SEED;
		rst_n = 1'b0;
		req = 1'b0;
		data = '0;
		repeat (10) @(posedge clock);
		#2;
		rst_n = 1'b1;

		// apply the table, random extra gap only where a gap exists
		for (int i = 0; i < NUM_WORDS && !timed_out; i++) begin
			gap = gap_table[i];
			if (gap > 0) begin
				random_bits(3, extra);
				gap = gap + extra;
			end
			repeat (gap) begin
				@(posedge clock);
				#2;
			end
			send_word(data_table[i], gap >= WIDTH && locked); // long gap drains the slot
		end

		// every acked word has to reach the line
		wait_cycles = 0;
		while (!timed_out && expected_words.size() > 0 && wait_cycles < DRAIN_TIMEOUT) begin
			@(posedge clock);
			#2;
			wait_cycles++;
		end
		if (expected_words.size() > 0) begin
			$display("timeout: %0d acked words never appeared on the serial line",
				expected_words.size());
			timeouts++;
			timed_out = 1'b1;
		end

		// quiet host, line should carry only idle words now
		idle_start = idle_words;
		wait_cycles = 0;
		while (!timed_out && idle_words < idle_start + IDLE_WORDS_AFTER &&
			wait_cycles < (IDLE_WORDS_AFTER + 2) * WIDTH) begin
			@(posedge clock);
			#2;
			wait_cycles++;
		end
		if (!timed_out && idle_words < idle_start + IDLE_WORDS_AFTER) begin
			$display("timeout: idle words stopped after the last host word");
			timeouts++;
			timed_out = 1'b1;
		end

		if (!timed_out) begin
			check_value(data_words, NUM_WORDS, "data words on the line");
		end

		$display("checks %0d, errors %0d, timeouts %0d, idle words %0d, data words %0d",
			checks, errors, timeouts, idle_words, data_words);
		if (errors == 0 && timeouts == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== serial_tx_top.sv ====
`timescale 1ns/1ps

module serial_tx_top (
	input  logic clock, // fast bit clock
	input  logic rst_n, // synchronous, active low
	input  logic req, // host request
	input  logic [oserdes_pkg::WIDTH-1:0] data, // host word
	output logic ack, // host acknowledge
	output logic serial_out, // serial line
	output logic serializer_strobe, // marks the cycle before a word's first bit
	output logic locked // link ready
);

	logic [oserdes_pkg::WIDTH-1:0] word; // buffer slot to serializer
	logic word_valid; // slot full
	logic word_taken; // slot drained

	// clock block, strobe and lock
	oserdes_pll oserdes_pll_inst (
		.clock  (clock),
		.rst_n  (rst_n),
		.strobe (serializer_strobe),
		.locked (locked)
	);

	// host side holding buffer
	tx_word_buffer tx_word_buffer_inst (
		.clock      (clock),
		.rst_n      (rst_n),
		.locked     (locked),
		.req        (req),
		.data       (data),
		.ack        (ack),
		.word       (word),
		.word_valid (word_valid),
		.word_taken (word_taken)
	);

	// parallel to serial
	oserdes_serializer oserdes_serializer_inst (
		.clock      (clock),
		.rst_n      (rst_n),
		.locked     (locked),
		.strobe     (serializer_strobe),
		.word       (word),
		.word_valid (word_valid),
		.word_taken (word_taken),
		.serial_out (serial_out)
	);

endmodule

// ==== oserdes_serializer.sv ====
`timescale 1ns/1ps

module oserdes_serializer (
	input  logic clock, // bit clock
	input  logic rst_n, // synchronous, active low
	input  logic locked, // link ready
	input  logic strobe, // word load strobe
	input  logic [oserdes_pkg::WIDTH-1:0] word, // word from the holding slot
	input  logic word_valid, // slot is full
	output logic word_taken, // slot consumed this cycle
	output logic serial_out // bit stream, msb first
);

	logic [oserdes_pkg::WIDTH-1:0] shift_reg; // word being sent
	logic load; // strobe on a locked link
	logic active; // set after the first load

	assign load = strobe && locked;

	// handshake back to the buffer, same cycle as the load
	assign word_taken = load && word_valid;

	// shift register, loads at the strobe and shifts msb out every cycle
	always_ff @(posedge clock) begin
		if (load) begin
			if (word_valid) begin
				shift_reg <= word; // host data
			end else begin
				shift_reg <= oserdes_pkg::IDLE_WORD; // nothing waiting
			end
		end else begin
			shift_reg <= {shift_reg[oserdes_pkg::WIDTH-2:0], 1'b0};
		end
	end

	// line stays quiet until the first word is loaded
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else if (load) begin
			active <= 1'b1;
		end
	end

	// msb of the loaded word shows up the cycle after the strobe
	assign serial_out = active & shift_reg[oserdes_pkg::WIDTH-1];

	// a taken word has to leave the slot or it would go out twice
	assert property (@(posedge clock) disable iff (!rst_n)
		word_taken |=> !word_valid)
		else $error("slot still full after the serializer took it");

endmodule

// ==== tx_word_buffer.sv ====
`timescale 1ns/1ps

module tx_word_buffer (
	input  logic clock, // bit clock
	input  logic rst_n, // synchronous, active low
	input  logic locked, // link ready from the clock block
	input  logic req, // host request, four phase
	input  logic [oserdes_pkg::WIDTH-1:0] data, // host word, stable while req is high
	output logic ack, // host acknowledge
	output logic [oserdes_pkg::WIDTH-1:0] word, // holding slot contents
	output logic word_valid, // slot is full
	input  logic word_taken // serializer took the slot this cycle
);

	logic [1:0] state; // handshake fsm
	logic can_take; // slot free and link up
	logic capture; // latch data this cycle

	assign can_take = locked && !word_valid;

	// a request is taken from idle or while it waits on the slot
	assign capture = req && can_take && (state != oserdes_pkg::ST_CAPTURED);

	// handshake fsm and slot flag
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= oserdes_pkg::ST_IDLE;
			ack <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			if (word_taken) begin
				word_valid <= 1'b0; // serializer drained the slot
			end
			case (state)
				oserdes_pkg::ST_IDLE, oserdes_pkg::ST_WAIT_RELEASE: begin
					if (capture) begin
						ack <= 1'b1; // one cycle after req, or after the slot frees
						word_valid <= 1'b1;
						state <= oserdes_pkg::ST_CAPTURED;
					end else if (req) begin
						state <= oserdes_pkg::ST_WAIT_RELEASE; // full slot or no lock yet
					end else begin
						state <= oserdes_pkg::ST_IDLE; // request withdrawn
					end
				end
				oserdes_pkg::ST_CAPTURED: begin
					if (!req) begin
						ack <= 1'b0; // drops one cycle after req
						state <= oserdes_pkg::ST_IDLE;
					end
				end
				default: begin
					ack <= 1'b0;
					state <= oserdes_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// holding register
	always_ff @(posedge clock) begin
		if (capture) begin
			word <= data;
		end
	end

	// ack answers a request, never a low req
	assert property (@(posedge clock) disable iff (!rst_n)
		$rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

endmodule

// ==== oserdes_pll.sv ====
`timescale 1ns/1ps

module oserdes_pll (
	input  logic clock, // fast bit clock
	input  logic rst_n, // synchronous, active low
	output logic strobe, // one bit clock wide, once per word period
	output logic locked // pll locked and strobe aligned
);

	// stand-in for the pll lock output
	logic pll_locked; // acquisition done
	logic [oserdes_pkg::LOCK_BITS-1:0] lock_count; // counts toward LOCK_CYCLES

	// stand-in for the bufpll divider
	logic [oserdes_pkg::PHASE_BITS-1:0] phase; // position within the word period
	logic strobe_aligned; // sticky once the first strobe is out
	logic at_last_phase; // divider is about to wrap

	assign at_last_phase = pll_locked && (phase == oserdes_pkg::LAST_PHASE);

	// lock acquisition model
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			lock_count <= '0;
			pll_locked <= 1'b0;
		end else if (!pll_locked) begin
			if (lock_count == oserdes_pkg::LOCK_BITS'(oserdes_pkg::LOCK_CYCLES - 1)) begin
				pll_locked <= 1'b1; // count freezes from here on
			end else begin
				lock_count <= lock_count + 1'b1;
			end
		end
	end

	// divide by WIDTH phase counter, runs only once the pll is locked
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (pll_locked) begin
			if (phase == oserdes_pkg::LAST_PHASE) begin
				phase <= '0; // wrap each word period
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// registered strobe, first pulse lands WIDTH cycles after pll lock
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			strobe <= 1'b0;
			strobe_aligned <= 1'b0;
		end else begin
			strobe <= at_last_phase; // one pulse per period
			if (at_last_phase) begin
				strobe_aligned <= 1'b1; // rises with the first strobe
			end
		end
	end

	// same combination the bufpll lock gives on silicon
	assign locked = pll_locked & strobe_aligned;

	// strobe period is WIDTH >= 2, so two back to back pulses mean a broken divider
	assert property (@(posedge clock) disable iff (!rst_n)
		strobe |=> !strobe)
		else $error("serializer strobe high on two consecutive cycles");

	// datapath relies on lock never dropping outside reset
	assert property (@(posedge clock) disable iff (!rst_n)
		locked |=> locked)
		else $error("locked fell while out of reset");

endmodule

// ==== oserdes_pkg.sv ====
package oserdes_pkg;

	// serialization factor
	localparam int WIDTH = 8; // bits per word and bit clocks per strobe period, 2 to 8

	// modeled pll acquisition
	localparam int LOCK_CYCLES = 64; // bit clocks from reset release to pll lock
	localparam int LOCK_BITS = $clog2(LOCK_CYCLES); // lock counter width

	// strobe phase counter
	localparam int PHASE_BITS = 3; // holds 0 to WIDTH-1
	localparam logic [PHASE_BITS-1:0] LAST_PHASE = PHASE_BITS'(WIDTH - 1); // strobe fires here

	// word sent on the line when the host has nothing waiting
	localparam logic [WIDTH-1:0] IDLE_WORD = WIDTH'(8'h3c); // balanced comma-like pattern

	// handshake fsm encodings for the holding buffer
	localparam logic [1:0] ST_IDLE = 2'd0; // no request seen
	localparam logic [1:0] ST_CAPTURED = 2'd1; // ack high, waiting for req to drop
	localparam logic [1:0] ST_WAIT_RELEASE = 2'd2; // req pending until the slot is released

endpackage
